// File: verilog/bcast_pkg.sv
// shared sizes and beat types of the single-clock stream broadcaster

package bcast_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // output channels fed from the one input stream
  localparam int NUM_CHAN = 4;

  // data field of one beat
  localparam int DATA_W = 32;

  // beats held per channel FIFO
  // counted with the output register included
  localparam int FIFO_DEPTH = 8;

  // memory behind the output register
  localparam int MEM_DEPTH = FIFO_DEPTH - 1;

  // memory pointer width
  localparam int PTR_W = $clog2(MEM_DEPTH);

  // occupancy counter, must reach FIFO_DEPTH itself
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  //////////////////////////////
  // beat types
  //////////////////////////////

  // one stream beat, payload of every link
  // data in the upper bits, last in bit 0
  typedef struct packed {
    logic [DATA_W-1:0] data;
    // end of packet
    logic              last;
  } beat_t;

  // all output channels side by side
  // channel n sits at index n
  typedef beat_t [NUM_CHAN-1:0] beat_vec_t;

endpackage

// File: verilog/bcast_distrib.sv
// broadcast distributor that holds each input beat until every channel has taken it

`timescale 1ns/1ps

module bcast_distrib
  import bcast_pkg::*;
(
  input  logic                s_axis_clk,
  input  logic                rst_n,

  // input stream
  input  logic                s_valid,
  output logic                s_ready,
  input  beat_t               s_beat,

  // per-channel links toward the FIFOs
  output logic [NUM_CHAN-1:0] ch_valid,
  input  logic [NUM_CHAN-1:0] ch_ready,
  output beat_t               ch_beat
);

  //////////////////////////////
  // state and handshakes
  //////////////////////////////

  // one flag per channel
  // set once that channel has taken the current beat
  logic [NUM_CHAN-1:0] taken;

  // transfers on each side
  logic                s_fire;
  logic [NUM_CHAN-1:0] ch_fire;

  //////////////////////////////
  // input side
  //////////////////////////////

  // accept only when every channel holds a copy
  // flags are registered, so this costs one extra cycle per beat
  assign s_ready = &taken;

  assign s_fire = s_valid & s_ready;

  //////////////////////////////
  // channel side
  //////////////////////////////

  // offer the beat only to channels still missing it
  assign ch_valid = s_valid ? ~taken : '0;

  // same beat on every channel, fanned out as wires
  assign ch_beat = s_beat;

  assign ch_fire = ch_valid & ch_ready;

  //////////////////////////////
  // taken flags
  //////////////////////////////

  // collect channel transfers for the beat in flight
  // clear all at the input transfer so the next beat starts fresh
  always_ff @(posedge s_axis_clk) begin
    if (!rst_n) begin
      // nothing taken yet, s_ready low out of reset
      taken <= '0;
    end else if (s_fire) begin
      taken <= '0;
    end else begin
      // a slow channel keeps its flag low and stalls the input
      taken <= taken | ch_fire;
    end
  end

endmodule

// File: verilog/bcast_fifo.sv
// per-channel beat FIFO of the broadcaster with valid/ready on both sides

`timescale 1ns/1ps

module bcast_fifo
  import bcast_pkg::*;
(
  input  logic  s_axis_clk,
  input  logic  rst_n,

  // write side from the distributor
  input  logic  wr_valid,
  output logic  wr_ready,
  input  beat_t wr_beat,

  // read side toward the consumer
  output logic  rd_valid,
  input  logic  rd_ready,
  output beat_t rd_beat
);

  //////////////////////////////
  // storage
  //////////////////////////////

  // circular buffer behind the output register
  beat_t            mem [MEM_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // beats held in total, output register included
  logic [CNT_W-1:0] cnt;
  // beats held in memory only
  logic [CNT_W-1:0] mem_cnt;

  // output register
  logic             out_valid;
  beat_t            out_beat;

  // handshakes and steering
  logic             wr_fire;
  logic             rd_fire;
  logic             out_free;
  logic             mem_empty;
  logic             mem_rd;
  logic             mem_wr;
  logic             bypass;

  // pointer step with wrap at MEM_DEPTH
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(MEM_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  //////////////////////////////
  // flow control
  //////////////////////////////

  // full only at FIFO_DEPTH beats
  assign wr_ready = (cnt != CNT_W'(FIFO_DEPTH));

  assign wr_fire = wr_valid & wr_ready;
  assign rd_fire = out_valid & rd_ready;

  assign mem_cnt   = cnt - CNT_W'(out_valid);
  assign mem_empty = (mem_cnt == '0);

  // output register empty now or emptied by this read
  assign out_free = ~out_valid | rd_fire;

  // refill from memory first to keep order
  assign mem_rd = out_free & ~mem_empty;

  // empty memory and free register
  // new beat goes straight to the output, visible next cycle
  assign bypass = out_free & mem_empty & wr_fire;

  // every other write lands in memory
  assign mem_wr = wr_fire & ~bypass;

  //////////////////////////////
  // datapath
  //////////////////////////////

  always_ff @(posedge s_axis_clk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  // output register refilled as reads drain it, no bubble
  always_ff @(posedge s_axis_clk) begin
    if (mem_rd) begin
      out_beat <= mem[rd_ptr];
    end else if (bypass) begin
      out_beat <= wr_beat;
    end
  end

  //////////////////////////////
  // control
  //////////////////////////////

  always_ff @(posedge s_axis_clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      cnt       <= '0;
      out_valid <= 1'b0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (mem_rd) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // read and write may land in the same cycle
      cnt <= cnt + CNT_W'(wr_fire) - CNT_W'(rd_fire);
      if (out_free) begin
        out_valid <= mem_rd | bypass;
      end
    end
  end

  assign rd_valid = out_valid;
  assign rd_beat  = out_beat;

endmodule

// File: verilog/bcast_top.sv
// top level of the stream broadcaster with the distributor and one FIFO per channel

`timescale 1ns/1ps

module bcast_top
  import bcast_pkg::*;
(
  input  logic                s_axis_clk,
  input  logic                rst_n,

  // input stream
  input  logic                s_valid,
  output logic                s_ready,
  input  beat_t               s_beat,

  // output channels
  output logic [NUM_CHAN-1:0] m_valid,
  input  logic [NUM_CHAN-1:0] m_ready,
  output beat_vec_t           m_beat
);

  //////////////////////////////
  // distributor to FIFO links
  //////////////////////////////

  logic [NUM_CHAN-1:0] ch_valid;
  logic [NUM_CHAN-1:0] ch_ready;
  // one beat shared by all channels
  beat_t               ch_beat;

  //////////////////////////////
  // distributor
  //////////////////////////////

  bcast_distrib u_distrib (
    .s_axis_clk (s_axis_clk),
    .rst_n      (rst_n),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_beat     (s_beat),
    .ch_valid   (ch_valid),
    .ch_ready   (ch_ready),
    .ch_beat    (ch_beat)
  );

  //////////////////////////////
  // channel FIFOs
  //////////////////////////////

  // one FIFO per channel
  // a slow consumer only stalls the input once its FIFO fills
  for (genvar n = 0; n < NUM_CHAN; n++) begin : g_chan
    bcast_fifo u_fifo (
      .s_axis_clk (s_axis_clk),
      .rst_n      (rst_n),
      .wr_valid   (ch_valid[n]),
      .wr_ready   (ch_ready[n]),
      .wr_beat    (ch_beat),
      .rd_valid   (m_valid[n]),
      .rd_ready   (m_ready[n]),
      .rd_beat    (m_beat[n])
    );
  end

endmodule

// File: testbench/tb_clock_gen.sv
// testbench clock and reset source, 20 ns clock with reset held low for two cycles

`timescale 1ns/1ps

module tb_clock_gen (
  output logic s_axis_clk,
  output logic rst_n
);

  // half of the 20 ns period
  localparam int HALF_PERIOD = 10;

  initial begin
    s_axis_clk = 1'b0;
    forever #(HALF_PERIOD) s_axis_clk = ~s_axis_clk;
  end

  // synchronous reset, seen low on the first two rising edges
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge s_axis_clk);
    rst_n <= 1'b1;
  end

endmodule

// File: testbench/tb_bcast_top.sv
// testbench of the stream broadcaster with reference model, output compare and watchdog

`timescale 1ns/1ps

module tb_bcast_top
  import bcast_pkg::*;
();

  //////////////////////////////
  // test sizes
  //////////////////////////////

  localparam int ALL_READY_BEATS = 64;
  localparam int RANDOM_BEATS    = 200;
  localparam int STALL_BEATS     = 32;
  localparam int PACKET_BEATS    = 48;
  localparam int TOTAL_BEATS     = ALL_READY_BEATS + RANDOM_BEATS + STALL_BEATS + PACKET_BEATS;
  // 40 cycles per beat plus slack for reset and settling
  localparam int WATCH_CYCLES    = 40 * TOTAL_BEATS + 1000;
  localparam logic [15:0] LFSR_SEED = 16'd31865;
  localparam int STALL_CHAN      = 2;

  // m_ready patterns
  localparam int RDY_ALL    = 0;
  localparam int RDY_RANDOM = 1;
  localparam int RDY_STALL  = 2;

  //////////////////////////////
  // DUT and clock
  //////////////////////////////

  logic                s_axis_clk;
  logic                rst_n;
  logic                s_valid = 1'b0;
  logic                s_ready;
  beat_t               s_beat  = '0;
  logic [NUM_CHAN-1:0] m_valid;
  logic [NUM_CHAN-1:0] m_ready = '0;
  beat_vec_t           m_beat;

  tb_clock_gen u_clk (
    .s_axis_clk (s_axis_clk),
    .rst_n      (rst_n)
  );

  bcast_top uut (
    .s_axis_clk (s_axis_clk),
    .rst_n      (rst_n),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_beat     (s_beat),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .m_beat     (m_beat)
  );

  //////////////////////////////
  // stimulus and bookkeeping
  //////////////////////////////

  logic [DATA_W-1:0] stim_data [TOTAL_BEATS];
  logic              stim_last [TOTAL_BEATS];

  // set by the sequencer and read by the driver
  int ready_mode = RDY_ALL;
  logic gap_mode = 1'b0;
  int send_end   = 0;

  // driver side
  int next_idx = 0;
  int acc_cnt  = 0;
  int last_in  = 0;
  logic [15:0] rnd_state = LFSR_SEED;

  // compare side per channel
  int rx_cnt   [NUM_CHAN] = '{default: 0};
  int last_out [NUM_CHAN] = '{default: 0};
  int err_cmp = 0;

  // sequencer side
  int err_seq      = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  // x^16 + x^14 + x^13 + x^11 + 1
  // new bit enters at bit 0
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // reference model
  // every channel sees the k-th input beat as its k-th output beat
  // last marks every fourth beat
  function automatic beat_t expected_beat(input int k);
    beat_t b;
    b.data = stim_data[k];
    b.last = ((k % 4) == 3);
    return b;
  endfunction

  // counter in the upper half and LFSR bits in the lower half
  task automatic gen_stimulus();
    logic [15:0] lfsr;
    logic [15:0] rnd;
    int          pos;
    lfsr = LFSR_SEED;
    pos  = 0;
    for (int k = 0; k < TOTAL_BEATS; k++) begin
      for (int b = 0; b < 16; b++) begin
        lfsr   = lfsr_next(lfsr);
        rnd[b] = lfsr[0];
      end
      stim_data[k] = {16'(k), rnd};
      stim_last[k] = (pos == 3);
      pos = (pos == 3) ? 0 : pos + 1;
    end
  endtask

  //////////////////////////////
  // input driver
  //////////////////////////////

  always @(posedge s_axis_clk) begin : drive_inputs
    logic in_fire;
    logic offer;
    in_fire = s_valid && s_ready;
    if (!rst_n) begin
      s_valid <= 1'b0;
      m_ready <= '0;
    end else begin
      if (in_fire) begin
        acc_cnt++;
        if (s_beat.last) begin
          last_in++;
        end
      end
      // a raised beat stays until its transfer
      if (!(s_valid && !in_fire)) begin
        offer = (next_idx < send_end);
        if (offer && gap_mode) begin
          rnd_state = lfsr_next(rnd_state);
          offer     = rnd_state[0];
        end
        if (offer) begin
          s_valid     <= 1'b1;
          s_beat.data <= stim_data[next_idx];
          s_beat.last <= stim_last[next_idx];
          next_idx++;
        end else begin
          s_valid <= 1'b0;
        end
      end
      // consumer side back-pressure
      case (ready_mode)
        RDY_RANDOM: begin
          for (int n = 0; n < NUM_CHAN; n++) begin
            rnd_state  = lfsr_next(rnd_state);
            m_ready[n] <= rnd_state[0];
          end
        end
        RDY_STALL: begin
          m_ready             <= '1;
          m_ready[STALL_CHAN] <= 1'b0;
        end
        default: m_ready <= '1;
      endcase
    end
  end

  //////////////////////////////
  // output compare
  //////////////////////////

  always @(posedge s_axis_clk) begin : compare_outputs
    beat_t exp_beat;
    int    k;
    if (rst_n) begin
      for (int n = 0; n < NUM_CHAN; n++) begin
        if (m_valid[n] && m_ready[n]) begin
          k = rx_cnt[n];
          if (k >= TOTAL_BEATS) begin
            $display("channel %0d delivered a beat beyond the %0d that were sent", n, TOTAL_BEATS);
            err_cmp++;
          end else begin
            exp_beat = expected_beat(k);
            if (m_beat[n] !== exp_beat) begin
              $display("Error: m_beat[%0d] beat %0d expected 0x%h got 0x%h",
                       n, k, exp_beat, m_beat[n]);
              err_cmp++;
            end
          end
          if (m_beat[n].last) begin
            last_out[n]++;
          end
          rx_cnt[n]++;
        end
      end
    end
  end

  //////////////////////////////
  // sequencer helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s expected 0x%h got 0x%h", name, exp, got);
      err_seq++;
    end
  endtask

  // all beats up to target accepted and delivered everywhere
  task automatic wait_for_drain(input int target);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge s_axis_clk);
      done = (acc_cnt == target);
      for (int n = 0; n < NUM_CHAN; n++) begin
        if (rx_cnt[n] != target) begin
          done = 1'b0;
        end
      end
    end
  endtask

  // nothing extra may show up after a few idle cycles
  task automatic check_settled(input int target);
    repeat (4) @(negedge s_axis_clk);
    check_value("m_valid", 32'(m_valid), 32'h0);
    for (int n = 0; n < NUM_CHAN; n++) begin
      check_value($sformatf("beats on channel %0d", n), rx_cnt[n], target);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = err_cmp + err_seq - errs_before;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s, %0d errors", tests_run, name, (errs == 0) ? "ok" : "fail", errs);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin : run_tests
    int base;
    int errs0;
    int lin0;
    int lout0 [NUM_CHAN];
    gen_stimulus();
    while (rst_n !== 1'b1) @(negedge s_axis_clk);

    // reset state with nothing offered yet
    errs0 = err_cmp + err_seq;
    repeat (4) begin
      @(negedge s_axis_clk);
      check_value("s_ready", 32'(s_ready), 32'h0);
      check_value("m_valid", 32'(m_valid), 32'h0);
    end
    report_test("reset state", errs0);

    // every consumer always ready
    errs0      = err_cmp + err_seq;
    base       = acc_cnt;
    ready_mode = RDY_ALL;
    send_end   = base + ALL_READY_BEATS;
    wait_for_drain(send_end);
    check_settled(send_end);
    report_test("all channels ready", errs0);

    // random back-pressure per channel
    errs0      = err_cmp + err_seq;
    base       = acc_cnt;
    ready_mode = RDY_RANDOM;
    send_end   = base + RANDOM_BEATS;
    wait_for_drain(send_end);
    check_settled(send_end);
    report_test("random back-pressure", errs0);

    // channel 2 stalled so its FIFO fills and blocks the input
    errs0      = err_cmp + err_seq;
    base       = acc_cnt;
    ready_mode = RDY_STALL;
    send_end   = base + STALL_BEATS;
    while (acc_cnt < base + FIFO_DEPTH) @(negedge s_axis_clk);
    repeat (4 * FIFO_DEPTH) begin
      @(negedge s_axis_clk);
      check_value("s_ready", 32'(s_ready), 32'h0);
    end
    check_value("accepted beats while stalled", acc_cnt - base, FIFO_DEPTH);
    // stalled channel holds its oldest beat on the output
    check_value($sformatf("m_valid[%0d]", STALL_CHAN), 32'(m_valid[STALL_CHAN]), 32'h1);
    // ready channels also got the pending beat
    for (int n = 0; n < NUM_CHAN; n++) begin
      if (n != STALL_CHAN) begin
        check_value($sformatf("beats on channel %0d while stalled", n),
                    rx_cnt[n] - base, FIFO_DEPTH + 1);
      end
    end
    ready_mode = RDY_ALL;
    wait_for_drain(send_end);
    check_settled(send_end);
    report_test("stalled channel", errs0);

    // packet boundaries with gaps on the input and random ready
    errs0 = err_cmp + err_seq;
    base  = acc_cnt;
    lin0  = last_in;
    for (int n = 0; n < NUM_CHAN; n++) begin
      lout0[n] = last_out[n];
    end
    ready_mode = RDY_RANDOM;
    gap_mode   = 1'b1;
    send_end   = base + PACKET_BEATS;
    wait_for_drain(send_end);
    check_settled(send_end);
    // each channel sees as many packet ends as the input took
    for (int n = 0; n < NUM_CHAN; n++) begin
      check_value($sformatf("packets on channel %0d", n), last_out[n] - lout0[n],
                  last_in - lin0);
    end
    gap_mode   = 1'b0;
    ready_mode = RDY_ALL;
    report_test("packet boundaries", errs0);

    $display("summary: %0d tests, %0d failed, %0d beats accepted, %0d errors",
             tests_run, tests_failed, acc_cnt, err_cmp + err_seq);
    if (tests_failed == 0 && err_cmp + err_seq == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  //////////////////////////////
  // watchdog
  //////////////////////////////

  initial begin : watchdog
    repeat (WATCH_CYCLES) @(posedge s_axis_clk);
    $display("watchdog: the tests did not finish within %0d cycles, a stream is stuck",
             WATCH_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: axis_bcast.f
verilog/bcast_pkg.sv
verilog/bcast_distrib.sv
verilog/bcast_fifo.sv
verilog/bcast_top.sv
testbench/tb_clock_gen.sv
testbench/tb_bcast_top.sv

// File: Makefile
# build and run the broadcaster testbench with Verilator

TOP := tb_bcast_top

.PHONY: sim clean

# fails unless the run prints the pass line
sim:
	verilator --binary --timing -Wno-fatal -f axis_bcast.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
